// ==== design/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // device type code, top nibble of every control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;

    // 2 KB part, top 3 bits select the 256-byte block
    localparam int ADDR_W = 11;

    typedef logic [7:0] byte_t;

    typedef enum logic [1:0] {
        CMD_START,
        CMD_WRITE,
        CMD_READ,
        CMD_STOP
    } bit_cmd_e;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RESTART,
        S_CTRL_R,
        S_READ,
        S_STOP,
        S_DONE
    } seq_state_e;

endpackage

`default_nettype wire

// ==== design/host_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface host_req_if import eeprom_pkg::*; ();

    logic              req_valid;   // level, held for the whole transaction
    logic              req_write;
    logic [ADDR_W-1:0] req_addr;
    byte_t             req_wdata;
    logic              done;        // one cycle
    byte_t             rdata;       // valid with done

    modport port (
        output req_valid, req_write, req_addr, req_wdata,
        input  done, rdata
    );

    modport seq (
        input  req_valid, req_write, req_addr, req_wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

// ==== design/bit_cmd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface bit_cmd_if import eeprom_pkg::*; ();

    logic     cmd_start;   // strobe, only while the engine is idle
    bit_cmd_e cmd;
    byte_t    tx_byte;
    logic     cmd_done;    // pulse at the end of the last half period
    byte_t    rx_byte;     // valid with cmd_done of a read

    modport seq (
        output cmd_start, cmd, tx_byte,
        input  cmd_done, rx_byte
    );

    modport eng (
        input  cmd_start, cmd, tx_byte,
        output cmd_done, rx_byte
    );

endinterface

`default_nettype wire

// ==== design/host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module host_port import eeprom_pkg::*;
(
    input  wire                CLK,
    input  wire                RESET,
    input  wire                wr,
    input  wire                rd,
    input  wire   [ADDR_W-1:0] addr,
    input  wire byte_t         wr_data,
    output byte_t              rd_data,
    output logic               ack,
    output logic               busy,
    host_req_if.port           req
);

    logic pending;
    logic accept;

    // strobes only count while nothing is pending
    assign accept = !pending && (wr || rd);

    assign busy          = pending;
    assign req.req_valid = pending;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pending <= 1'b0;
            ack     <= 1'b0;
        end
        else
        begin
            ack <= req.done;
            if (accept)
                pending <= 1'b1;
            else if (req.done)
                pending <= 1'b0;
        end
    end

    // request held for the sequencer
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.req_write <= wr;   // wr wins over rd
            req.req_addr  <= addr;
            req.req_wdata <= wr_data;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req.done && !req.req_write)
            rd_data <= req.rdata;
    end

    // ack closes a transaction that was busy, and busy is already down
    assert property (@(posedge CLK) disable iff (RESET)
        ack |-> $past(busy) && !busy);

endmodule

`default_nettype wire

// ==== design/eeprom_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_sequencer import eeprom_pkg::*;
(
    input  wire      CLK,
    input  wire      RESET,
    host_req_if.seq  req,
    bit_cmd_if.seq   bus
);

    seq_state_e state;
    seq_state_e nxt;
    logic       advance;
    bit_cmd_e   nxt_cmd;
    byte_t      nxt_tx;
    logic [2:0] blk;

    assign blk = req.req_addr[ADDR_W-1:8];

    assign req.done = (state == S_DONE);

    always_comb
    begin
        case (state)
            S_IDLE:    advance = req.req_valid;
            S_DONE:    advance = 1'b1;
            default:   advance = bus.cmd_done;
        endcase
    end

    always_comb
    begin
        case (state)
            S_IDLE:    nxt = S_START;
            S_START:   nxt = S_CTRL_W;
            S_CTRL_W:  nxt = S_ADDR;
            S_ADDR:    nxt = req.req_write ? S_DATA : S_RESTART;   // reads turn around here
            S_DATA:    nxt = S_STOP;
            S_RESTART: nxt = S_CTRL_R;
            S_CTRL_R:  nxt = S_READ;
            S_READ:    nxt = S_STOP;
            S_STOP:    nxt = S_DONE;
            default:   nxt = S_IDLE;
        endcase
    end

    // command belonging to the state we move into
    always_comb
    begin
        case (nxt)
            S_START,
            S_RESTART: nxt_cmd = CMD_START;
            S_READ:    nxt_cmd = CMD_READ;
            S_STOP:    nxt_cmd = CMD_STOP;
            default:   nxt_cmd = CMD_WRITE;
        endcase
    end

    always_comb
    begin
        case (nxt)
            S_CTRL_W:  nxt_tx = {DEV_CODE, blk, 1'b0};
            S_CTRL_R:  nxt_tx = {DEV_CODE, blk, 1'b1};
            S_ADDR:    nxt_tx = req.req_addr[7:0];
            default:   nxt_tx = req.req_wdata;   // don't care for start/read/stop
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state         <= S_IDLE;
            bus.cmd_start <= 1'b0;
        end
        else
        begin
            bus.cmd_start <= 1'b0;
            if (advance)
            begin
                state         <= nxt;
                bus.cmd_start <= !(nxt inside {S_IDLE, S_DONE});
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (advance)
        begin
            bus.cmd     <= nxt_cmd;
            bus.tx_byte <= nxt_tx;
        end
        if (state == S_READ && bus.cmd_done)
            req.rdata <= bus.rx_byte;
    end

    // commands only go out while the host holds a request
    assert property (@(posedge CLK) disable iff (RESET)
        bus.cmd_start |-> req.req_valid);

endmodule

`default_nettype wire

// ==== design/twi_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module twi_bit_engine import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  wire     CLK,
    input  wire     RESET,
    bit_cmd_if.eng  bus,
    output logic    scl,
    output logic    sda_oe,
    input  wire     sda_in
);

    localparam int CNT_W = $clog2(CLK_DIV + 1);

    logic             busy;
    logic             half;      // 0 = first half period of a bit
    logic [CNT_W-1:0] cnt;
    logic             tick;
    logic [3:0]       bit_cnt;   // 8 is the ack slot
    bit_cmd_e         cmd_q;
    byte_t            shreg;

    assign tick        = (cnt == CNT_W'(CLK_DIV - 1));
    assign bus.rx_byte = shreg;

    // scl rests low between commands of a transfer, high on an idle bus
    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy         <= 1'b0;
            half         <= 1'b0;
            cnt          <= '0;
            bit_cnt      <= '0;
            scl          <= 1'b1;
            sda_oe       <= 1'b0;
            bus.cmd_done <= 1'b0;
        end
        else
        begin
            bus.cmd_done <= 1'b0;
            if (bus.cmd_start)
            begin
                busy    <= 1'b1;
                half    <= 1'b0;
                cnt     <= '0;
                bit_cnt <= '0;
                case (bus.cmd)
                    CMD_START:
                    begin
                        scl    <= 1'b1;   // raises scl again on a restart
                        sda_oe <= 1'b0;
                    end
                    CMD_WRITE: sda_oe <= ~bus.tx_byte[7];
                    CMD_READ:  sda_oe <= 1'b0;
                    default:   sda_oe <= 1'b1;   // stop, pull low while scl low
                endcase
            end
            else if (busy)
            begin
                cnt <= tick ? '0 : cnt + 1'b1;
                if (tick && !half)
                begin
                    half <= 1'b1;
                    if (cmd_q == CMD_START)
                        sda_oe <= 1'b1;          // sda falls, scl high
                    else
                        scl <= 1'b1;
                end
                else if (tick)
                begin
                    half <= 1'b0;
                    if (cmd_q == CMD_STOP)
                    begin
                        sda_oe       <= 1'b0;    // sda rises, scl high
                        busy         <= 1'b0;
                        bus.cmd_done <= 1'b1;
                    end
                    else
                    begin
                        scl <= 1'b0;
                        if (cmd_q == CMD_START || bit_cnt == 4'd8)
                        begin
                            busy         <= 1'b0;
                            bus.cmd_done <= 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 4'd1;
                            // ack slot and read bits leave sda released
                            if (cmd_q == CMD_WRITE && bit_cnt != 4'd7)
                                sda_oe <= ~shreg[6];
                            else
                                sda_oe <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // one shifter for both directions, sampled at the end of scl high
    always_ff @(posedge CLK)
    begin
        if (bus.cmd_start)
        begin
            cmd_q <= bus.cmd;
            shreg <= bus.tx_byte;
        end
        else if (busy && tick && half && bit_cnt != 4'd8)
            shreg <= {shreg[6:0], sda_in};
    end

    assert property (@(posedge CLK) disable iff (RESET)
        $changed(sda_oe) && scl && $past(scl) |-> cmd_q inside {CMD_START, CMD_STOP});

    // the sequencer waits for cmd_done before the next command
    assert property (@(posedge CLK) disable iff (RESET)
        bus.cmd_start |-> !busy);

endmodule

`default_nettype wire

// ==== design/eeprom_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_ctrl_top import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  wire                CLK,
    input  wire                RESET,
    input  wire                wr,
    input  wire                rd,
    input  wire   [ADDR_W-1:0] addr,
    input  wire byte_t         wr_data,
    output wire byte_t         rd_data,
    output wire                ack,
    output wire                busy,
    output wire                scl,
    inout  wire                sda
);

    wire sda_oe;
    wire sda_in;

    host_req_if req_if ();
    bit_cmd_if  cmd_if ();

    host_port u_host (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy),
        .req     (req_if.port)
    );

    eeprom_sequencer u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .req   (req_if.seq),
        .bus   (cmd_if.seq)
    );

    twi_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_eng (
        .CLK    (CLK),
        .RESET  (RESET),
        .bus    (cmd_if.eng),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

    // open drain, the pull-up sits on the board
    assign sda    = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

`default_nettype wire

// ==== tb/eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_model
(
    input wire scl,
    inout wire sda
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_CTRL,
        P_ADDR,
        P_WDATA,
        P_RDATA
    } phase_e;

    logic [7:0]  mem [0:2047];
    logic [10:0] ptr;
    logic [2:0]  blk;
    logic        rw;
    logic [7:0]  shift;
    logic [3:0]  bit_cnt;   // bits clocked in this byte, 9 after the ack slot
    logic        pull_low;
    phase_e      phase;

    pullup (sda);
    assign sda = pull_low ? 1'b0 : 1'bz;

    initial
    begin
        pull_low = 1'b0;
        phase    = P_IDLE;
        bit_cnt  = '0;
        ptr      = '0;
        blk      = '0;
        rw       = 1'b0;
        shift    = '0;
        for (int a = 0; a < 2048; a++)
            mem[a] = a[7:0] ^ {5'b0, a[10:8]};
    end

    // start or restart
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase    = P_CTRL;
            bit_cnt  = '0;
            pull_low = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            phase    = P_IDLE;   // stop
            pull_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (phase != P_IDLE)
        begin
            if (phase != P_RDATA && bit_cnt < 8)
                shift = {shift[6:0], sda === 1'b1};
            bit_cnt = bit_cnt + 4'd1;
        end
    end

    always @(negedge scl)
    begin
        if (phase == P_RDATA)
        begin
            if (bit_cnt < 8)
                pull_low = ~shift[7 - bit_cnt];
            else if (bit_cnt == 8)
                pull_low = 1'b0;   // master answers with nack
            else
                phase = P_IDLE;
        end
        else if (phase != P_IDLE && bit_cnt == 8)
        begin
            pull_low = 1'b1;
            case (phase)
                P_CTRL:
                begin
                    blk = shift[3:1];
                    rw  = shift[0];
                    if (shift[7:4] != 4'b1010)
                    begin
                        pull_low = 1'b0;   // not our device type
                        phase    = P_IDLE;
                    end
                end
                P_ADDR:  ptr = {blk, shift};
                default: mem[ptr] = shift;
            endcase
        end
        else if (phase != P_IDLE && bit_cnt == 9)
        begin
            pull_low = 1'b0;
            bit_cnt  = '0;
            case (phase)
                P_CTRL:
                begin
                    if (rw)
                    begin
                        ptr      = {blk, ptr[7:0]};
                        shift    = mem[ptr];
                        pull_low = ~shift[7];
                        phase    = P_RDATA;
                    end
                    else
                        phase = P_ADDR;
                end
                P_ADDR:  phase = P_WDATA;
                default: phase = P_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== tb/txn_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module txn_checker import eeprom_pkg::*;
(
    input  wire              CLK,
    input  wire              RESET,
    input  wire              wr,
    input  wire              rd,
    input  wire [ADDR_W-1:0] addr,
    input  wire [7:0]        wr_data,
    input  wire [7:0]        rd_data,
    input  wire              ack,
    input  wire              busy,
    input  wire              scl,
    input  wire              sda,
    input  wire [8*12-1:0]   test_name,
    input  wire              tbl_chk,
    input  wire [7:0]        tbl_exp,
    output int               errors,
    output int               accepted,
    output int               reads
);

    logic [7:0]    shadow [0:2047];
    int            outstanding;
    logic          started;   // first request seen
    logic          acc_q;
    logic          op_write;
    logic          op_chk;
    logic [7:0]    op_exp;
    logic [7:0]    op_tbl;
    logic [8*12-1:0] op_name;

    initial
    begin
        errors      = 0;
        accepted    = 0;
        reads       = 0;
        outstanding = 0;
        started     = 1'b0;
        acc_q       = 1'b0;
        for (int a = 0; a < 2048; a++)
            shadow[a] = a[7:0] ^ {5'b0, a[10:8]};
    end

    task automatic check_byte(input logic [8*12-1:0] name, input logic [7:0] exp,
                              input logic [7:0] act);
        if (act !== exp)
        begin
            errors++;
            $display("[ERROR] %0s expected %02h actual %02h", name, exp, act);
        end
    endtask

    task automatic check_drained(input int expected);
        if (outstanding != 0)
        begin
            errors++;
            $display("a request was accepted but never acknowledged");
        end
        if (accepted != expected)
        begin
            errors++;
            $display("%0d requests accepted while %0d were applied", accepted, expected);
        end
    endtask

    always @(posedge CLK)
    begin
        if (!RESET)
        begin
            if (!started && (busy !== 1'b0 || ack !== 1'b0 || scl !== 1'b1 || sda !== 1'b1))
            begin
                errors++;
                $display("bus or host side not idle after reset, busy %b ack %b scl %b sda %b",
                         busy, ack, scl, sda);
            end
            if (acc_q && busy !== 1'b1)
            begin
                errors++;
                $display("busy did not rise after an accepted request");
            end
            if (ack === 1'b1)
            begin
                if (outstanding == 0)
                begin
                    errors++;
                    $display("ack arrived with no request outstanding");
                end
                else
                begin
                    outstanding--;
                    if (!op_write)
                    begin
                        reads++;
                        check_byte(op_name, op_exp, rd_data);
                        if (op_chk)
                            check_byte(op_name, op_tbl, rd_data);   // table value too
                    end
                end
            end
            acc_q = 1'b0;
            if (busy === 1'b0 && (wr || rd))
            begin
                started     = 1'b1;
                acc_q       = 1'b1;
                accepted++;
                outstanding++;
                op_write    = wr;
                op_name     = test_name;
                op_chk      = tbl_chk && !wr;
                op_tbl      = tbl_exp;
                op_exp      = shadow[addr];
                if (wr)
                    shadow[addr] = wr_data;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_top import eeprom_pkg::*;
();

    localparam int CLK_DIV  = 4;
    localparam int N_DIR    = 14;
    localparam int N_RND    = 24;
    localparam int N_ROWS   = N_DIR + N_RND;
    localparam int NAME_W   = 8 * 12;
    // 65 bit times per row, two half periods of CLK_DIV cycles each
    localparam int LIMIT_NS = N_ROWS * 65 * 2 * CLK_DIV * 10 + 2000;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wr_data;
    wire  [7:0]        rd_data;
    wire               ack;
    wire               busy;
    wire               scl;
    wire               sda;

    logic [NAME_W-1:0] cur_name;
    logic              cur_chk;
    logic [7:0]        cur_exp;
    int                errors;
    int                accepted;
    int                reads;
    int                n_rows;
    logic [31:0]       seed;

    // stimulus table, op bit 0 is wr and bit 1 is rd
    logic [NAME_W-1:0] t_name [N_ROWS];
    logic [1:0]        t_op   [N_ROWS];
    logic [ADDR_W-1:0] t_addr [N_ROWS];
    logic [7:0]        t_data [N_ROWS];
    logic              t_chk  [N_ROWS];
    logic [7:0]        t_exp  [N_ROWS];
    logic              t_poke [N_ROWS];   // strobes again while busy

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .busy    (busy),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model mem_model (
        .scl (scl),
        .sda (sda)
    );

    txn_checker chk (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .ack       (ack),
        .busy      (busy),
        .scl       (scl),
        .sda       (sda),
        .test_name (cur_name),
        .tbl_chk   (cur_chk),
        .tbl_exp   (cur_exp),
        .errors    (errors),
        .accepted  (accepted),
        .reads     (reads)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_row(input logic [NAME_W-1:0] name, input logic [1:0] op,
                           input logic [ADDR_W-1:0] a, input logic [7:0] d,
                           input logic chk_en, input logic [7:0] exp, input logic poke);
        t_name[n_rows] = name;
        t_op[n_rows]   = op;
        t_addr[n_rows] = a;
        t_data[n_rows] = d;
        t_chk[n_rows]  = chk_en;
        t_exp[n_rows]  = exp;
        t_poke[n_rows] = poke;
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        add_row("wr_a",      2'b01, 11'h123, 8'h5a, 1'b0, 8'h00, 1'b0);
        add_row("rd_a",      2'b10, 11'h123, 8'h00, 1'b1, 8'h5a, 1'b0);
        add_row("wr_blk0",   2'b01, 11'h045, 8'h11, 1'b0, 8'h00, 1'b0);
        add_row("wr_blk5",   2'b01, 11'h545, 8'h22, 1'b0, 8'h00, 1'b0);
        add_row("wr_blk7",   2'b01, 11'h745, 8'h33, 1'b0, 8'h00, 1'b0);
        add_row("rd_blk0",   2'b10, 11'h045, 8'h00, 1'b1, 8'h11, 1'b0);
        add_row("rd_blk5",   2'b10, 11'h545, 8'h00, 1'b1, 8'h22, 1'b0);
        add_row("rd_blk7",   2'b10, 11'h745, 8'h00, 1'b1, 8'h33, 1'b0);
        // never written, low byte xor block
        add_row("rd_fresh3", 2'b10, 11'h345, 8'h00, 1'b1, 8'h46, 1'b0);
        add_row("rd_fresh7", 2'b10, 11'h7ff, 8'h00, 1'b1, 8'hf8, 1'b0);
        add_row("wr_poke",   2'b01, 11'h200, 8'hc3, 1'b0, 8'h00, 1'b1);
        add_row("rd_poke",   2'b10, 11'h200, 8'h00, 1'b1, 8'hc3, 1'b1);
        add_row("wr_both",   2'b11, 11'h201, 8'h77, 1'b0, 8'h00, 1'b0);   // wr wins
        add_row("rd_both",   2'b10, 11'h201, 8'h00, 1'b1, 8'h77, 1'b0);
        seed = 32'd51166;
        for (int k = 0; k < N_RND; k++)
        begin
            seed = lcg_next(seed);
            // few low addresses per block so reads hit earlier writes
            add_row("random", seed[20] ? 2'b01 : 2'b10, {seed[30:28], 5'd0, seed[26:24]},
                    seed[15:8], 1'b0, 8'h00, 1'b0);
        end
    endtask

    // called on a rising edge, returns on the edge where ack was seen
    task automatic run_row(input int i);
        #1;
        cur_name = t_name[i];
        cur_chk  = t_chk[i];
        cur_exp  = t_exp[i];
        wr       = t_op[i][0];
        rd       = t_op[i][1];
        addr     = t_addr[i];
        wr_data  = t_data[i];
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        if (t_poke[i])
        begin
            repeat (4) @(posedge CLK);
            #1;
            wr      = 1'b1;
            wr_data = ~t_data[i];
            @(posedge CLK);
            #1;
            wr = 1'b0;
            rd = 1'b1;
            @(posedge CLK);
            #1;
            rd = 1'b0;
        end
        @(posedge CLK);
        while (ack !== 1'b1)
            @(posedge CLK);
    endtask

    initial
    begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial
    begin
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wr_data  = '0;
        cur_name = "reset";
        cur_chk  = 1'b0;
        cur_exp  = 8'h00;
        build_table();
        repeat (10) @(posedge CLK);
        #1 RESET = 1'b0;
        repeat (5) @(posedge CLK);   // idle bus watched by the checker
        for (int i = 0; i < N_ROWS; i++)
            run_row(i);
        repeat (3) @(posedge CLK);
        chk.check_drained(N_ROWS);
        $display("requests %0d, reads checked %0d, errors %0d", accepted, reads, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

    initial
    begin
        #(LIMIT_NS);
        $display("timeout after %0d ns, a transaction never finished with ack", LIMIT_NS);
        $display("requests %0d, reads checked %0d, errors %0d", accepted, reads, errors + 1);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/eeprom_pkg.sv
design/host_req_if.sv
design/bit_cmd_if.sv
design/host_port.sv
design/eeprom_sequencer.sv
design/twi_bit_engine.sv
design/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/txn_checker.sv
tb/tb_top.sv
